/* design/arf_debug_apb.sv */
`timescale 1ns/1ns

module arf_debug_apb
   import arf_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,            // sync, active high
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  logic [APB_ADDR_W-1:0] paddr,
   input  xdata_t                pwdata,
   output xdata_t                prdata,
   output logic                  pready,
   output logic                  pslverr,
   input  xdata_t                dbg_rdata,      // word at dbg_addr
   input  logic                  dbg_grant,      // no core write on this index
   output logic                  dbg_wen,        // write request to decoder
   output reg_addr_t             dbg_addr,       // index from paddr
   output xdata_t                dbg_wdata       // data from pwdata
);

   logic access;                                 // APB access phase
   logic done_q;                                 // this access already ended
   logic live;                                   // access not yet completed
   logic oor;                                    // address outside the ARF

   // **************************************************
   // address decode
   // **************************************************
   assign dbg_addr  = paddr[APB_IDX_MSB:APB_IDX_LSB];
   assign oor       = paddr[APB_OOR_BIT];
   assign dbg_wdata = pwdata;                    // master holds it in wait states

   assign access = psel & penable;
   assign live   = access & ~done_q;

   // **************************************************
   // request and response, combinational from APB
   // **************************************************
   assign dbg_wen = live & pwrite & ~oor;        // held while grant is low

   // reads and bad addresses finish at once, writes wait for the grant
   assign pready  = live & (oor | ~pwrite | dbg_grant);
   assign pslverr = live & oor;

   assign prdata  = (live & ~pwrite & ~oor) ? dbg_rdata : '0;

   // **************************************************
   // completion flag
   // **************************************************
   always_ff @(posedge clk) begin
      if (rst) begin
         done_q <= 1'b0;
      end
      else if (!access) begin
         done_q <= 1'b0;                         // idle or setup phase
      end
      else if (pready) begin
         done_q <= 1'b1;                         // blocks a second issue
      end
   end

endmodule

/* design/arf_entry.sv */
`timescale 1ns/1ns

module arf_entry
   import arf_pkg::*;
(
   input  logic    clk,
   input  logic    rst,                          // sync, active high
   input  wr_sel_t sel,                          // one-hot or empty
   input  xdata_t  wd0,                          // pipe writeback data
   input  xdata_t  wd1,                          // nonblock load data
   input  xdata_t  wd2,                          // divide data
   input  xdata_t  dbg_wdata,                    // debugger data
   output xdata_t  q                             // current register word
);

   xdata_t d;                                    // selected next word
   logic   we;                                   // any source picked

   // **************************************************
   // and-or mux, legal because sel is one-hot
   // **************************************************
   always_comb begin
      d = ({XLEN{sel[WP_PIPE]}}   & wd0) |
          ({XLEN{sel[WP_NBLOAD]}} & wd1) |
          ({XLEN{sel[WP_DIV]}}    & wd2) |
          ({XLEN{sel[WP_DBG]}}    & dbg_wdata);
   end

   assign we = |sel;

   // **************************************************
   // the register itself
   // **************************************************
   always_ff @(posedge clk) begin
      if (rst) begin
         q <= '0;                                // arch state starts at zero
      end
      else if (we) begin
         q <= d;                                 // visible from next cycle
      end
   end

endmodule

/* design/arf_pkg.sv */
package arf_pkg;

   // **************************************************
   // register file geometry
   // **************************************************
   localparam int XLEN       = 32;                // register word width
   localparam int NUM_REGS   = 32;                // x0 .. x31
   localparam int REG_ADDR_W = 5;                 // log2 of NUM_REGS

   // **************************************************
   // write sources, listed in priority order
   // **************************************************
   localparam int NUM_WR_PORTS = 4;
   localparam int WP_PIPE      = 0;               // R stage writeback, highest
   localparam int WP_NBLOAD    = 1;               // non-blocking load return
   localparam int WP_DIV       = 2;               // divider result
   localparam int WP_DBG       = 3;               // debugger write, lowest

   // **************************************************
   // APB debug map
   // **************************************************
   localparam int APB_ADDR_W  = 8;                // byte address into the map
   localparam int APB_IDX_LSB = 2;                // word aligned register index
   localparam int APB_IDX_MSB = APB_IDX_LSB + REG_ADDR_W - 1;
   localparam int APB_OOR_BIT = 7;                // set means outside the ARF

   // one architectural register word
   typedef logic [XLEN-1:0] xdata_t;

   // one register index
   typedef logic [REG_ADDR_W-1:0] reg_addr_t;

   // one-hot pick of a write source, bit n is source n
   typedef logic [NUM_WR_PORTS-1:0] wr_sel_t;

endpackage

/* design/arf_read_mux.sv */
`timescale 1ns/1ns

module arf_read_mux
   import arf_pkg::*;
(
   input  xdata_t [NUM_REGS-1:0] regs,           // whole array, slot 0 is zero
   input  reg_addr_t             raddr0,         // rs1 index from decode
   input  reg_addr_t             raddr1,         // rs2 index from decode
   input  reg_addr_t             dbg_addr,       // debugger index
   output xdata_t                rd0,            // rs1 word
   output xdata_t                rd1,            // rs2 word
   output xdata_t                dbg_rdata       // debugger read word
);

   // **************************************************
   // three independent selects off the same array
   // **************************************************

   // no bypass here, a write shows up after its edge

   always_comb begin
      rd0 = regs[raddr0];                        // rs1 at decode
   end

   always_comb begin
      rd1 = regs[raddr1];                        // rs2 at decode
   end

   always_comb begin
      dbg_rdata = regs[dbg_addr];                // debug abstract read
   end

endmodule

/* design/arf_top.sv */
`timescale 1ns/1ns

module arf_top
   import arf_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,            // sync, active high

   // core write ports, no handshake
   input  logic                  wen0,           // pipe writeback
   input  reg_addr_t             waddr0,
   input  xdata_t                wd0,
   input  logic                  wen1,           // nonblock load return
   input  reg_addr_t             waddr1,
   input  xdata_t                wd1,
   input  logic                  wen2,           // divide result
   input  reg_addr_t             waddr2,
   input  xdata_t                wd2,

   // decode read ports
   input  reg_addr_t             raddr0,         // rs1
   input  reg_addr_t             raddr1,         // rs2
   output xdata_t                rd0,
   output xdata_t                rd1,

   // APB debug slave
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  logic [APB_ADDR_W-1:0] paddr,
   input  xdata_t                pwdata,
   output xdata_t                prdata,
   output logic                  pready,
   output logic                  pslverr
);

   logic                  dbg_wen;               // apb to decoder
   reg_addr_t             dbg_addr;
   xdata_t                dbg_wdata;
   logic                  dbg_grant;             // decoder to apb
   xdata_t                dbg_rdata;             // read mux to apb
   wr_sel_t [NUM_REGS-1:0] wr_sel;               // per register source pick
   xdata_t  [NUM_REGS-1:0] regs;                 // array contents

   // **************************************************
   // write side
   // **************************************************
   arf_write_decode u_write_decode (
      .wen0(wen0), .waddr0(waddr0),
      .wen1(wen1), .waddr1(waddr1),
      .wen2(wen2), .waddr2(waddr2),
      .dbg_wen(dbg_wen), .dbg_addr(dbg_addr),
      .wr_sel(wr_sel), .dbg_grant(dbg_grant)
   );

   assign regs[0] = '0;                          // x0 hardwired

   for (genvar i = 1; i < NUM_REGS; i++) begin : g_entry
      arf_entry u_entry (
         .clk(clk), .rst(rst), .sel(wr_sel[i]),
         .wd0(wd0), .wd1(wd1), .wd2(wd2), .dbg_wdata(dbg_wdata),
         .q(regs[i])
      );
   end

   // **************************************************
   // read side and debug
   // **************************************************
   arf_read_mux u_read_mux (
      .regs(regs), .raddr0(raddr0), .raddr1(raddr1), .dbg_addr(dbg_addr),
      .rd0(rd0), .rd1(rd1), .dbg_rdata(dbg_rdata)
   );

   arf_debug_apb u_debug_apb (
      .clk(clk), .rst(rst),
      .psel(psel), .penable(penable), .pwrite(pwrite),
      .paddr(paddr), .pwdata(pwdata),
      .prdata(prdata), .pready(pready), .pslverr(pslverr),
      .dbg_rdata(dbg_rdata), .dbg_grant(dbg_grant),
      .dbg_wen(dbg_wen), .dbg_addr(dbg_addr), .dbg_wdata(dbg_wdata)
   );

endmodule

/* design/arf_write_decode.sv */
`timescale 1ns/1ns

module arf_write_decode
   import arf_pkg::*;
(
   input  logic                     wen0,       // pipe writeback enable
   input  reg_addr_t                waddr0,     // pipe writeback index
   input  logic                     wen1,       // nonblock load enable
   input  reg_addr_t                waddr1,     // nonblock load index
   input  logic                     wen2,       // divide enable
   input  reg_addr_t                waddr2,     // divide index
   input  logic                     dbg_wen,    // debugger write request
   input  reg_addr_t                dbg_addr,   // debugger index
   output wr_sel_t [NUM_REGS-1:0]   wr_sel,     // per register source pick
   output logic                     dbg_grant   // debug write may go this cycle
);

   logic core_hits_dbg;                          // some core port aims at the debug index

   // keep the lowest set bit, lowest index is the strongest source
   function automatic wr_sel_t first_hit(input wr_sel_t hit);
      wr_sel_t sel;
      sel = '0;
      for (int p = NUM_WR_PORTS - 1; p >= 0; p--) begin
         if (hit[p]) begin
            sel    = '0;                         // a stronger source replaces it
            sel[p] = 1'b1;
         end
      end
      return sel;
   endfunction

   // **************************************************
   // per register address match and priority pick
   // **************************************************
   assign wr_sel[0] = '0;                        // x0 never written

   for (genvar i = 1; i < NUM_REGS; i++) begin : g_sel
      wr_sel_t hit;                              // sources that aim at x[i]

      assign hit[WP_PIPE]   = wen0    & (waddr0   == reg_addr_t'(i));
      assign hit[WP_NBLOAD] = wen1    & (waddr1   == reg_addr_t'(i));
      assign hit[WP_DIV]    = wen2    & (waddr2   == reg_addr_t'(i));
      assign hit[WP_DBG]    = dbg_wen & (dbg_addr == reg_addr_t'(i));

      // debug bit only survives with no core hit, same as the grant
      assign wr_sel[i] = first_hit(hit);
   end

   // **************************************************
   // debug grant
   // **************************************************
   assign core_hits_dbg = (wen0 & (waddr0 == dbg_addr)) |
                          (wen1 & (waddr1 == dbg_addr)) |
                          (wen2 & (waddr2 == dbg_addr));

   // x0 write is a no-op, so it never has to wait
   assign dbg_grant = (dbg_addr == '0) | ~core_hits_dbg;

endmodule

/* flist.f */
design/arf_pkg.sv
design/arf_write_decode.sv
design/arf_entry.sv
design/arf_read_mux.sv
design/arf_debug_apb.sv
design/arf_top.sv
tb/tb_arf.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the ARF testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_arf -f flist.f
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

out=$(./obj_dir/Vtb_arf)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if ! echo "$out" | grep -qF '*** PASSED ***'; then
   echo "pass message not found in simulation output"
   exit 1
fi
exit 0

/* tb/tb_arf.sv */
`timescale 1ns/1ns

module tb_arf
   import arf_pkg::*;
();

   localparam logic [1:0] OP_NONE  = 2'd0;       // no APB transfer
   localparam logic [1:0] OP_READ  = 2'd1;
   localparam logic [1:0] OP_WRITE = 2'd2;
   localparam logic [1:0] OP_BAD   = 2'd3;       // write with paddr bit 7 set

   typedef struct packed {
      logic [2:0] wen;                           // bit 0 pipe, 1 nbload, 2 div
      reg_addr_t  waddr0;
      reg_addr_t  waddr1;
      reg_addr_t  waddr2;
      logic [1:0] op;                            // APB operation
      reg_addr_t  idx;                           // APB register index
      reg_addr_t  ra0;
      reg_addr_t  ra1;
      int         waits;                         // expected cycles with pready low
   } row_t;

   logic                  clk;
   logic                  rst;
   logic                  wen0, wen1, wen2;
   reg_addr_t             waddr0, waddr1, waddr2;
   xdata_t                wd0, wd1, wd2;
   reg_addr_t             raddr0, raddr1;
   xdata_t                rd0, rd1;
   logic                  psel, penable, pwrite;
   logic [APB_ADDR_W-1:0] paddr;
   xdata_t                pwdata, prdata;
   logic                  pready, pslverr;

   row_t        rows [$];                        // stimulus table
   xdata_t      model [NUM_REGS];                // expected register contents
   logic [31:0] lcg_state   = 32'd2;
   int          cycle_cnt   = 0;
   int          cycle_limit = 1000;              // reset once the table is built

   arf_top u_arf_top (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;                     // 10 ns period
   end

   // **************************************************
   // run limit
   // **************************************************
   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt >= cycle_limit) begin
         $display("timeout: the run went past %0d clock cycles", cycle_limit);
         $display("*** FAILED ***");
         $fatal(1, "timeout");
      end
   end

   function automatic xdata_t next_rand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   task automatic add_row(input int wen, input int a0, input int a1, input int a2,
                          input logic [1:0] op, input int idx, input int r0,
                          input int r1, input int waits);
      row_t r;
      r.wen    = 3'(wen);
      r.waddr0 = reg_addr_t'(a0);
      r.waddr1 = reg_addr_t'(a1);
      r.waddr2 = reg_addr_t'(a2);
      r.op     = op;
      r.idx    = reg_addr_t'(idx);
      r.ra0    = reg_addr_t'(r0);
      r.ra1    = reg_addr_t'(r1);
      r.waits  = waits;
      rows.push_back(r);
   endtask

   task automatic check(input logic ok, input string msg);
      assert (ok) else begin
         $display("CHECK FAILED at %0t: %s", $time, msg);
         $display("*** FAILED ***");
         $fatal(1, "stopped at first error");
      end
   endtask

   task automatic check_reads(input string where);
      check(rd0 == model[raddr0], $sformatf("rd0 x%0d in %s cycle: got %h, expected %h",
                                            raddr0, where, rd0, model[raddr0]));
      check(rd1 == model[raddr1], $sformatf("rd1 x%0d in %s cycle: got %h, expected %h",
                                            raddr1, where, rd1, model[raddr1]));
   endtask

   // weakest source first so stronger ones overwrite
   task automatic update_model(input logic dbg_wr, input reg_addr_t idx, input xdata_t data);
      if (dbg_wr && idx != '0) model[idx] = data;
      if (wen2 && waddr2 != '0) model[waddr2] = wd2;
      if (wen1 && waddr1 != '0) model[waddr1] = wd1;
      if (wen0 && waddr0 != '0) model[waddr0] = wd0;   // pipe wins
   endtask

   task automatic core_idle();
      wen0 = 1'b0;
      wen1 = 1'b0;
      wen2 = 1'b0;
   endtask

   // **************************************************
   // reset for 4 cycles and scan every register
   // **************************************************
   task automatic reset_and_scan();
      rst = 1'b1;
      repeat (4) @(posedge clk);
      #1;
      rst = 1'b0;
      foreach (model[i]) model[i] = '0;          // architectural state cleared
      for (int i = 0; i < NUM_REGS / 2; i++) begin
         @(posedge clk);
         #1;
         raddr0 = reg_addr_t'(i);
         raddr1 = reg_addr_t'(NUM_REGS - 1 - i);
         @(negedge clk);
         check_reads("reset scan");
         check(!pready && !pslverr, "APB response active after reset");
      end
   endtask

   // **************************************************
   // one table row through setup, access, waits and idle
   // **************************************************
   task automatic run_row(input row_t r, input int n);
      xdata_t pdat;
      logic   apb;
      int     waits;
      pdat = next_rand();
      apb  = (r.op != OP_NONE);
      @(posedge clk);
      #1;
      raddr0  = r.ra0;
      raddr1  = r.ra1;
      psel    = apb;                             // setup phase
      penable = 1'b0;
      pwrite  = (r.op != OP_READ);
      paddr   = {r.op == OP_BAD, r.idx, 2'b00};
      pwdata  = pdat;
      @(negedge clk);
      check_reads("setup");
      check(!pready && !pslverr, $sformatf("row %0d: response in setup phase", n));
      @(posedge clk);
      #1;
      penable = apb;                             // access phase
      wen0    = r.wen[0];
      waddr0  = r.waddr0;
      wd0     = next_rand();
      wen1    = r.wen[1];
      waddr1  = r.waddr1;
      wd1     = next_rand();
      wen2    = r.wen[2];
      waddr2  = r.waddr2;
      wd2     = next_rand();
      @(negedge clk);
      check_reads("access");
      waits = 0;
      while (apb && !pready) begin
         waits++;
         update_model(1'b0, r.idx, pdat);        // core write lands while debug is held
         @(posedge clk);
         #1;
         core_idle();                            // conflict gone
         @(negedge clk);
         check_reads("wait");
      end
      if (apb) begin
         check(waits == r.waits, $sformatf("row %0d: %0d wait cycles, expected %0d",
                                           n, waits, r.waits));
         check(pslverr == (r.op == OP_BAD), $sformatf("row %0d: pslverr is %b", n, pslverr));
         if (r.op == OP_READ)
            check(prdata == model[r.idx], $sformatf("row %0d: prdata %h, expected %h",
                                                    n, prdata, model[r.idx]));
      end
      else begin
         check(!pready, $sformatf("row %0d: pready high with no transfer", n));
      end
      update_model(r.op == OP_WRITE, r.idx, pdat);
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      core_idle();
      @(negedge clk);
      check_reads("idle");
      check(!pready && !pslverr, $sformatf("row %0d: response while idle", n));
   endtask

   initial begin
      rst     = 1'b1;
      core_idle();
      waddr0  = '0;
      waddr1  = '0;
      waddr2  = '0;
      wd0     = '0;
      wd1     = '0;
      wd2     = '0;
      raddr0  = '0;
      raddr1  = '0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;

      // wen  a0  a1  a2  op        idx  ra0 ra1 waits
      add_row(1,   5,  0,  0, OP_NONE,   0,   5,  5, 0);     // single pipe write
      add_row(2,   0,  6,  0, OP_NONE,   0,   6,  6, 0);     // single nbload write
      add_row(4,   0,  0,  7, OP_NONE,   0,   7,  7, 0);     // single div write
      add_row(7,   9,  9,  9, OP_NONE,   0,   9,  9, 0);     // three on x9
      add_row(6,   0, 10, 10, OP_NONE,   0,  10, 10, 0);     // nbload beats div
      add_row(7,  11, 12, 13, OP_NONE,   0,  11, 12, 0);     // distinct targets
      add_row(0,   0,  0,  0, OP_READ,  12,  13, 11, 0);
      add_row(7,   0,  0,  0, OP_WRITE,  0,   0,  0, 0);     // everything at x0
      add_row(0,   0,  0,  0, OP_WRITE, 14,  14,  5, 0);
      add_row(1,  15,  0,  0, OP_WRITE, 14,  14, 15, 0);     // core elsewhere
      add_row(1,  16,  0,  0, OP_WRITE, 16,  16, 16, 1);     // conflict with pipe
      add_row(4,   0,  0, 17, OP_WRITE, 17,  17,  0, 1);     // conflict with div
      add_row(0,   0,  0,  0, OP_BAD,    5,   5,  9, 0);
      add_row(0,   0,  0,  0, OP_READ,   0,   0, 16, 0);
      add_row(0,   0,  0,  0, OP_READ,  16,  16, 17, 0);
      add_row(1,  12,  0,  0, OP_READ,  12,  12, 12, 0);     // read sees old word
      cycle_limit = 4 * rows.size() + 50;

      reset_and_scan();

      foreach (rows[k]) run_row(rows[k], k);

      // a second reset clears the words the table left behind
      @(posedge clk);
      #1;
      reset_and_scan();

      $display("*** PASSED ***");
      $finish;
   end

endmodule
